// ==== accel_defs.svh ====
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Datapath widths
`define ACCEL_XLEN          64
`define ACCEL_ADDR_W        40
`define ACCEL_REG_W         5
`define ACCEL_FUNCT_W       7
`define ACCEL_OPCODE_W      7
`define ACCEL_TAG_W         10
`define ACCEL_MEM_CMD_W     5
`define ACCEL_MEM_TYP_W     3

// Operations selected by funct
`define ACCEL_FUNCT_STORE   7'd0
`define ACCEL_FUNCT_LOAD    7'd1
`define ACCEL_FUNCT_ADD     7'd2

// Memory port encodings
`define ACCEL_MEM_CMD_LOAD  5'd0
`define ACCEL_MEM_CMD_STORE 5'd1
`define ACCEL_MEM_TYP_DWORD 3'd3

`endif

// ==== accel_pkg.sv ====
`include "accel_defs.svh"

package accel_pkg;

  // Core command, 160 bits
  typedef struct packed {
    logic [`ACCEL_XLEN-1:0]     rs2_data;
    logic [`ACCEL_XLEN-1:0]     rs1_data;
    logic [`ACCEL_OPCODE_W-1:0] opcode;
    logic [`ACCEL_REG_W-1:0]    rd;
    logic                       xs2;
    logic                       xs1;
    logic                       xd;
    logic [`ACCEL_REG_W-1:0]    rs1;
    logic [`ACCEL_REG_W-1:0]    rs2;
    logic [`ACCEL_FUNCT_W-1:0]  funct;
  } rocc_cmd_t;

  // Response back to the core
  typedef struct packed {
    logic [`ACCEL_XLEN-1:0]  data;
    logic [`ACCEL_REG_W-1:0] rd;
  } rocc_resp_t;

  typedef struct packed {
    logic [`ACCEL_ADDR_W-1:0]    addr;
    logic [`ACCEL_TAG_W-1:0]     tag;
    logic [`ACCEL_MEM_CMD_W-1:0] cmd;
    logic [`ACCEL_MEM_TYP_W-1:0] typ;
    logic                        kill;
    logic                        phys;
    logic [`ACCEL_XLEN-1:0]      data;
  } mem_req_t;

  // Full memory response, only data and store_data are consumed
  typedef struct packed {
    logic [`ACCEL_ADDR_W-1:0]    addr;
    logic [`ACCEL_TAG_W-1:0]     tag;
    logic [`ACCEL_MEM_CMD_W-1:0] cmd;
    logic [`ACCEL_MEM_TYP_W-1:0] typ;
    logic [`ACCEL_XLEN-1:0]      data;
    logic                        nack;
    logic                        replay;
    logic                        has_data;
    logic [`ACCEL_XLEN-1:0]      data_word_bypass;
    logic [`ACCEL_XLEN-1:0]      store_data;
  } mem_resp_t;

  // Operands of the command in flight
  typedef struct packed {
    logic [`ACCEL_REG_W-1:0] rd;
    logic [`ACCEL_XLEN-1:0]  rs1_data;
    logic [`ACCEL_XLEN-1:0]  rs2_data;
  } accel_op_t;

  typedef struct packed {
    logic [`ACCEL_REG_W-1:0] rd;
    logic [`ACCEL_XLEN-1:0]  data;
  } accel_result_t;

endpackage

// ==== cmd_issue.sv ====
`include "accel_defs.svh"

module cmd_issue (
  input  logic                  dpath_clk,
  input  logic                  ctrl_rst,
  input  accel_pkg::rocc_cmd_t  cmd,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  retire,
  output accel_pkg::accel_op_t  op,
  output logic                  mem_start,
  output logic                  is_store,
  output logic                  add_start
);

  logic busy;
  logic cmd_xfer;
  logic funct_store;
  logic funct_load;
  logic funct_add;
  logic funct_known;

  // One command in flight at a time
  assign cmd_rdy  = !busy;
  assign cmd_xfer = cmd_vld && cmd_rdy;

  assign funct_store = (cmd.funct == `ACCEL_FUNCT_STORE);
  assign funct_load  = (cmd.funct == `ACCEL_FUNCT_LOAD);
  assign funct_add   = (cmd.funct == `ACCEL_FUNCT_ADD);
  assign funct_known = funct_store || funct_load || funct_add;

  always_ff @(posedge dpath_clk) begin
    if (ctrl_rst) begin
      busy      <= 1'b0;
      mem_start <= 1'b0;
      add_start <= 1'b0;
    end else begin
      mem_start <= cmd_xfer && (funct_store || funct_load);
      add_start <= cmd_xfer && funct_add;
      // Unknown funct is swallowed and the unit stays idle
      if (cmd_xfer && funct_known) begin
        busy <= 1'b1;
      end else if (retire) begin
        busy <= 1'b0;
      end
    end
  end

  // Operand latch
  always_ff @(posedge dpath_clk) begin
    if (cmd_xfer) begin
      op.rd       <= cmd.rd;
      op.rs1_data <= cmd.rs1_data;
      op.rs2_data <= cmd.rs2_data;
      is_store    <= funct_store;
    end
  end

  // Response stage only retires work that was issued here
  a_retire_busy: assert property (
    @(posedge dpath_clk) disable iff (ctrl_rst)
    retire |-> busy
  );

endmodule

// ==== mem_sequencer.sv ====
`include "accel_defs.svh"

module mem_sequencer (
  input  logic                     dpath_clk,
  input  logic                     ctrl_rst,
  input  accel_pkg::accel_op_t     op,
  input  logic                     mem_start,
  input  logic                     is_store,
  output accel_pkg::mem_req_t      mem_req,
  output logic                     mem_req_vld,
  input  logic                     mem_req_rdy,
  input  accel_pkg::mem_resp_t     mem_resp,
  input  logic                     mem_resp_vld,
  output accel_pkg::accel_result_t result,
  output logic                     done
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  logic [1:0] state;
  logic [1:0] state_nxt;
  logic       req_xfer;
  logic       resp_hit;

  assign mem_req_vld = (state == ST_REQ);
  assign req_xfer    = mem_req_vld && mem_req_rdy;
  // Strobes outside the wait state are not ours
  assign resp_hit    = (state == ST_WAIT) && mem_resp_vld;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (mem_start) begin
          state_nxt = ST_REQ;
        end
      end
      ST_REQ: begin
        if (req_xfer) begin
          state_nxt = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (resp_hit) begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge dpath_clk) begin
    if (ctrl_rst) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= resp_hit;
    end
  end

  // Request fields are fixed for the whole exchange
  always_ff @(posedge dpath_clk) begin
    if (mem_start) begin
      mem_req.addr <= op.rs2_data[`ACCEL_ADDR_W-1:0];
      mem_req.tag  <= '0;
      mem_req.cmd  <= is_store ? `ACCEL_MEM_CMD_STORE : `ACCEL_MEM_CMD_LOAD;
      mem_req.typ  <= `ACCEL_MEM_TYP_DWORD;
      mem_req.kill <= 1'b0;
      mem_req.phys <= 1'b1;
      mem_req.data <= op.rs1_data;
      result.rd    <= op.rd;
    end
  end

  // Store answers with the echo, load with the fetched word
  always_ff @(posedge dpath_clk) begin
    if (resp_hit) begin
      if (mem_req.cmd == `ACCEL_MEM_CMD_STORE) begin
        result.data <= mem_resp.store_data;
      end else begin
        result.data <= mem_resp.data;
      end
    end
  end

  a_req_stable: assert property (
    @(posedge dpath_clk) disable iff (ctrl_rst)
    mem_req_vld && !mem_req_rdy |=> mem_req_vld && $stable(mem_req)
  );

  a_start_idle: assert property (
    @(posedge dpath_clk) disable iff (ctrl_rst)
    mem_start |-> state == ST_IDLE
  );

endmodule

// ==== add_unit.sv ====
module add_unit (
  input  logic                     dpath_clk,
  input  logic                     ctrl_rst,
  input  accel_pkg::accel_op_t     op,
  input  logic                     add_start,
  output accel_pkg::accel_result_t result,
  output logic                     done
);

  always_ff @(posedge dpath_clk) begin
    if (ctrl_rst) begin
      done <= 1'b0;
    end else begin
      done <= add_start;
    end
  end

  // Carry out is dropped, sum wraps at XLEN
  always_ff @(posedge dpath_clk) begin
    if (add_start) begin
      result.rd   <= op.rd;
      result.data <= op.rs1_data + op.rs2_data;
    end
  end

endmodule

// ==== resp_merge.sv ====
module resp_merge (
  input  logic                     dpath_clk,
  input  logic                     ctrl_rst,
  input  accel_pkg::accel_result_t mem_result,
  input  logic                     mem_done,
  input  accel_pkg::accel_result_t add_result,
  input  logic                     add_done,
  output accel_pkg::rocc_resp_t    resp,
  output logic                     resp_vld,
  input  logic                     resp_rdy,
  output logic                     retire
);

  accel_pkg::accel_result_t sel_result;
  logic                     any_done;

  assign any_done   = mem_done || add_done;
  assign sel_result = mem_done ? mem_result : add_result;
  assign retire     = resp_vld && resp_rdy;

  always_ff @(posedge dpath_clk) begin
    if (ctrl_rst) begin
      resp_vld <= 1'b0;
    end else if (any_done) begin
      resp_vld <= 1'b1;
    end else if (retire) begin
      resp_vld <= 1'b0;
    end
  end

  // Held until the core takes it
  always_ff @(posedge dpath_clk) begin
    if (any_done) begin
      resp.data <= sel_result.data;
      resp.rd   <= sel_result.rd;
    end
  end

  // Only one unit runs per command
  a_done_onehot: assert property (
    @(posedge dpath_clk) disable iff (ctrl_rst)
    !(mem_done && add_done)
  );

  a_done_not_full: assert property (
    @(posedge dpath_clk) disable iff (ctrl_rst)
    any_done |-> !resp_vld
  );

endmodule

// ==== rocc_mem_accel.sv ====
module rocc_mem_accel (
  input  logic                  dpath_clk,
  input  logic                  ctrl_rst,
  input  accel_pkg::rocc_cmd_t  cmd,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output accel_pkg::rocc_resp_t resp,
  output logic                  resp_vld,
  input  logic                  resp_rdy,
  output accel_pkg::mem_req_t   mem_req,
  output logic                  mem_req_vld,
  input  logic                  mem_req_rdy,
  input  accel_pkg::mem_resp_t  mem_resp,
  input  logic                  mem_resp_vld
);

  accel_pkg::accel_op_t     op;
  accel_pkg::accel_result_t mem_result;
  accel_pkg::accel_result_t add_result;
  logic                     mem_start;
  logic                     is_store;
  logic                     add_start;
  logic                     mem_done;
  logic                     add_done;
  logic                     retire;

  cmd_issue u_cmd_issue (
    .dpath_clk (dpath_clk),
    .ctrl_rst  (ctrl_rst),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .retire    (retire),
    .op        (op),
    .mem_start (mem_start),
    .is_store  (is_store),
    .add_start (add_start)
  );

  mem_sequencer u_mem_sequencer (
    .dpath_clk    (dpath_clk),
    .ctrl_rst     (ctrl_rst),
    .op           (op),
    .mem_start    (mem_start),
    .is_store     (is_store),
    .mem_req      (mem_req),
    .mem_req_vld  (mem_req_vld),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_vld (mem_resp_vld),
    .result       (mem_result),
    .done         (mem_done)
  );

  add_unit u_add_unit (
    .dpath_clk (dpath_clk),
    .ctrl_rst  (ctrl_rst),
    .op        (op),
    .add_start (add_start),
    .result    (add_result),
    .done      (add_done)
  );

  resp_merge u_resp_merge (
    .dpath_clk  (dpath_clk),
    .ctrl_rst   (ctrl_rst),
    .mem_result (mem_result),
    .mem_done   (mem_done),
    .add_result (add_result),
    .add_done   (add_done),
    .resp       (resp),
    .resp_vld   (resp_vld),
    .resp_rdy   (resp_rdy),
    .retire     (retire)
  );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 4
) (
  output logic dpath_clk,
  output logic ctrl_rst
);

  initial begin
    dpath_clk = 1'b0;
    forever begin
      #(PERIOD / 2) dpath_clk = ~dpath_clk;
    end
  end

  // Release on a falling edge, in step with the stimulus
  initial begin
    ctrl_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge dpath_clk);
    @(negedge dpath_clk);
    ctrl_rst = 1'b0;
  end

endmodule

// ==== tb_rocc_mem_accel.sv ====
`include "accel_defs.svh"

module tb_rocc_mem_accel;

  localparam int CLK_PERIOD    = 40;
  localparam int RST_CYCLES    = 4;
  localparam int N_CMDS        = 18;
  localparam int CMD_CYCLES    = 200;
  localparam int MARGIN        = 2;
  localparam int RESP_LIMIT    = 200;
  localparam int WATCHDOG_TIME = (RST_CYCLES + N_CMDS * CMD_CYCLES) * MARGIN * CLK_PERIOD;

  logic                  dpath_clk;
  logic                  ctrl_rst;
  accel_pkg::rocc_cmd_t  cmd;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  accel_pkg::rocc_resp_t resp;
  logic                  resp_vld;
  logic                  resp_rdy;
  accel_pkg::mem_req_t   mem_req;
  logic                  mem_req_vld;
  logic                  mem_req_rdy;
  accel_pkg::mem_resp_t  mem_resp;
  logic                  mem_resp_vld;

  // Memory contents seen through the port
  logic [`ACCEL_XLEN-1:0] mem_words [logic [`ACCEL_ADDR_W-1:0]];
  int mem_req_count = 0;
  int mem_vld_cycles = 0;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_tb_clock_gen (
    .dpath_clk (dpath_clk),
    .ctrl_rst  (ctrl_rst)
  );

  rocc_mem_accel u_rocc_mem_accel (
    .dpath_clk    (dpath_clk),
    .ctrl_rst     (ctrl_rst),
    .cmd          (cmd),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .resp         (resp),
    .resp_vld     (resp_vld),
    .resp_rdy     (resp_rdy),
    .mem_req      (mem_req),
    .mem_req_vld  (mem_req_vld),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_vld (mem_resp_vld)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic compare_resp(input string sig, input accel_pkg::rocc_resp_t got,
                              input accel_pkg::rocc_resp_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", sig, got, exp);
      stop_run("Response mismatch");
    end
  endtask

  task automatic compare_mem_req(input string sig, input accel_pkg::mem_req_t got,
                                 input accel_pkg::mem_req_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", sig, got, exp);
      stop_run("Memory request mismatch");
    end
  endtask

  task automatic compare_flag(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", sig, got, exp);
      stop_run("Handshake signal mismatch");
    end
  endtask

  task automatic compare_count(input string sig, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", sig, got, exp);
      stop_run("Count mismatch");
    end
  endtask

  function automatic logic [`ACCEL_REG_W-1:0] rand_rd();
    logic [31:0] r;
    r = $urandom;
    return r[`ACCEL_REG_W-1:0];
  endfunction

  function automatic logic [`ACCEL_XLEN-1:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic accel_pkg::rocc_cmd_t make_cmd(
    input logic [`ACCEL_FUNCT_W-1:0] funct,
    input logic [`ACCEL_REG_W-1:0]   rd,
    input logic [`ACCEL_XLEN-1:0]    rs1_data,
    input logic [`ACCEL_XLEN-1:0]    rs2_data
  );
    accel_pkg::rocc_cmd_t c;
    c          = '0;
    c.funct    = funct;
    c.rd       = rd;
    c.rs1      = 5'd10;
    c.rs2      = 5'd11;
    c.xd       = 1'b1;
    c.xs1      = 1'b1;
    c.xs2      = 1'b1;
    c.opcode   = 7'h0b;
    c.rs1_data = rs1_data;
    c.rs2_data = rs2_data;
    return c;
  endfunction

  function automatic accel_pkg::mem_req_t expect_req(
    input logic                   is_st,
    input logic [`ACCEL_XLEN-1:0] rs1_data,
    input logic [`ACCEL_XLEN-1:0] rs2_data
  );
    accel_pkg::mem_req_t r;
    r      = '0;
    r.addr = rs2_data[`ACCEL_ADDR_W-1:0];
    r.cmd  = is_st ? `ACCEL_MEM_CMD_STORE : `ACCEL_MEM_CMD_LOAD;
    r.typ  = `ACCEL_MEM_TYP_DWORD;
    r.phys = 1'b1;
    r.data = rs1_data;
    return r;
  endfunction

  // Returns on the falling edge after the accepting edge
  task automatic send_cmd(input accel_pkg::rocc_cmd_t c);
    int waited;
    waited = 0;
    @(negedge dpath_clk);
    cmd     = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy) begin
      @(negedge dpath_clk);
      waited++;
      if (waited > RESP_LIMIT) begin
        stop_run("The DUT never became ready for a command");
      end
    end
    @(negedge dpath_clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_resp(input logic check_req, input accel_pkg::mem_req_t exp_req,
                           output int cycles);
    cycles = 0;
    while (!resp_vld) begin
      if (check_req && mem_req_vld) begin
        compare_mem_req("mem_req", mem_req, exp_req);
      end
      @(negedge dpath_clk);
      cycles++;
      if (cycles > RESP_LIMIT) begin
        stop_run("No response from the DUT within the cycle limit");
      end
    end
  endtask

  // Holds resp_rdy low for stall cycles, then takes the response
  task automatic take_resp(input int stall, output accel_pkg::rocc_resp_t got);
    got = resp;
    compare_flag("cmd_rdy", cmd_rdy, 1'b0);
    repeat (stall) begin
      @(negedge dpath_clk);
      compare_resp("resp", resp, got);
      compare_flag("resp_vld", resp_vld, 1'b1);
      compare_flag("cmd_rdy", cmd_rdy, 1'b0);
    end
    resp_rdy = 1'b1;
    @(negedge dpath_clk);
    resp_rdy = 1'b0;
    compare_flag("resp_vld", resp_vld, 1'b0);
    compare_flag("cmd_rdy", cmd_rdy, 1'b1);
  endtask

  task automatic do_mem_cmd(input logic is_st, input logic [`ACCEL_REG_W-1:0] rd,
                            input logic [`ACCEL_XLEN-1:0] rs1_data,
                            input logic [`ACCEL_XLEN-1:0] rs2_data,
                            input int stall, output accel_pkg::rocc_resp_t got);
    int cycles;
    int req_before;
    logic [`ACCEL_FUNCT_W-1:0] funct;
    funct      = is_st ? `ACCEL_FUNCT_STORE : `ACCEL_FUNCT_LOAD;
    req_before = mem_req_count;
    send_cmd(make_cmd(funct, rd, rs1_data, rs2_data));
    wait_resp(1'b1, expect_req(is_st, rs1_data, rs2_data), cycles);
    compare_count("mem_req transfers", mem_req_count - req_before, 1);
    take_resp(stall, got);
  endtask

  task automatic test_add(input int count);
    accel_pkg::rocc_resp_t exp;
    accel_pkg::rocc_resp_t got;
    logic [`ACCEL_XLEN-1:0] a;
    logic [`ACCEL_XLEN-1:0] b;
    int cycles;
    int vld_before;
    repeat (count) begin
      a          = rand_word();
      b          = rand_word();
      exp.rd     = rand_rd();
      exp.data   = a + b;
      vld_before = mem_vld_cycles;
      send_cmd(make_cmd(`ACCEL_FUNCT_ADD, exp.rd, a, b));
      wait_resp(1'b0, '0, cycles);
      // Valid in the third cycle, counted from the first falling edge
      compare_count("resp_vld latency", cycles, 2);
      take_resp($urandom_range(2, 0), got);
      compare_resp("resp", got, exp);
      compare_count("mem_req_vld cycles", mem_vld_cycles - vld_before, 0);
    end
  endtask

  task automatic test_store(input int count);
    accel_pkg::rocc_resp_t exp;
    accel_pkg::rocc_resp_t got;
    logic [`ACCEL_XLEN-1:0] addr;
    repeat (count) begin
      addr                     = rand_word();
      addr[`ACCEL_ADDR_W-1]    = 1'b0;
      exp.rd                   = rand_rd();
      exp.data                 = rand_word();
      do_mem_cmd(1'b1, exp.rd, exp.data, addr, $urandom_range(1, 0), got);
      compare_resp("resp", got, exp);
    end
  endtask

  task automatic test_store_load(input int count);
    accel_pkg::rocc_resp_t exp;
    accel_pkg::rocc_resp_t got;
    logic [`ACCEL_XLEN-1:0] addr;
    logic [`ACCEL_XLEN-1:0] word;
    repeat (count) begin
      addr                  = rand_word();
      addr[`ACCEL_ADDR_W-1] = 1'b0;
      word                  = rand_word();
      do_mem_cmd(1'b1, rand_rd(), word, addr, 0, got);
      exp.rd   = rand_rd();
      exp.data = word;
      do_mem_cmd(1'b0, exp.rd, rand_word(), addr, $urandom_range(1, 0), got);
      compare_resp("resp", got, exp);
    end
  endtask

  task automatic test_backpressure();
    accel_pkg::rocc_resp_t exp;
    accel_pkg::rocc_resp_t got;
    logic [`ACCEL_XLEN-1:0] a;
    logic [`ACCEL_XLEN-1:0] b;
    int cycles;
    a        = rand_word();
    b        = rand_word();
    exp.rd   = rand_rd();
    exp.data = a + b;
    send_cmd(make_cmd(`ACCEL_FUNCT_ADD, exp.rd, a, b));
    wait_resp(1'b0, '0, cycles);
    take_resp($urandom_range(6, 2), got);
    compare_resp("resp", got, exp);
    // Stores keep address bit 39 low, so this one was never written
    b                  = rand_word();
    b[`ACCEL_ADDR_W-1] = 1'b1;
    exp.rd             = rand_rd();
    exp.data           = '0;
    do_mem_cmd(1'b0, exp.rd, rand_word(), b, $urandom_range(6, 2), got);
    compare_resp("resp", got, exp);
  endtask

  task automatic test_unknown_funct();
    logic [`ACCEL_FUNCT_W-1:0] bad [2];
    bad[0] = 7'd3;
    bad[1] = 7'h7f;
    foreach (bad[i]) begin
      send_cmd(make_cmd(bad[i], rand_rd(), rand_word(), rand_word()));
      compare_flag("cmd_rdy", cmd_rdy, 1'b1);
      repeat (8) begin
        @(negedge dpath_clk);
        compare_flag("resp_vld", resp_vld, 1'b0);
        compare_flag("mem_req_vld", mem_req_vld, 1'b0);
        compare_flag("cmd_rdy", cmd_rdy, 1'b1);
      end
    end
    test_add(1);
  endtask

  task automatic test_reset_state();
    @(negedge dpath_clk);
    while (ctrl_rst !== 1'b0) begin
      @(negedge dpath_clk);
    end
    compare_flag("cmd_rdy", cmd_rdy, 1'b1);
    compare_flag("resp_vld", resp_vld, 1'b0);
    compare_flag("mem_req_vld", mem_req_vld, 1'b0);
  endtask

  always @(negedge dpath_clk) begin
    if (mem_req_vld) begin
      mem_vld_cycles <= mem_vld_cycles + 1;
    end
  end

  // Random ready stalls, then a strobe 1 to 5 cycles after the transfer
  initial begin : memory_model
    accel_pkg::mem_req_t req;
    int delay;
    mem_req_rdy  = 1'b0;
    mem_resp_vld = 1'b0;
    mem_resp     = '0;
    forever begin
      @(negedge dpath_clk);
      mem_resp_vld = 1'b0;
      mem_req_rdy  = !ctrl_rst && mem_req_vld && ($urandom_range(1, 0) == 1);
      if (mem_req_rdy) begin
        req = mem_req;
        @(negedge dpath_clk);
        mem_req_rdy = 1'b0;
        mem_req_count++;
        delay = $urandom_range(5, 1);
        repeat (delay - 1) @(negedge dpath_clk);
        mem_resp      = '0;
        mem_resp.addr = req.addr;
        mem_resp.cmd  = req.cmd;
        mem_resp.typ  = req.typ;
        if (req.cmd == `ACCEL_MEM_CMD_STORE) begin
          mem_words[req.addr] = req.data;
          mem_resp.store_data = req.data;
          mem_resp.data       = rand_word();
        end else begin
          mem_resp.has_data   = 1'b1;
          mem_resp.store_data = rand_word();
          mem_resp.data       = mem_words.exists(req.addr) ? mem_words[req.addr] : '0;
        end
        mem_resp_vld = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    stop_run("Watchdog expired, no response came in time");
  end

  initial begin
    void'($urandom(32'h92b9));
    cmd      = '0;
    cmd_vld  = 1'b0;
    resp_rdy = 1'b0;
    test_reset_state();
    test_add(4);
    test_store(3);
    test_store_load(3);
    test_backpressure();
    test_unknown_funct();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== rocc_mem_accel.f ====
+incdir+.
accel_pkg.sv
cmd_issue.sv
mem_sequencer.sv
add_unit.sv
resp_merge.sv
rocc_mem_accel.sv
tb_clock_gen.sv
tb_rocc_mem_accel.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_rocc_mem_accel \
  -f rocc_mem_accel.f \
  -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
